// File: mipsPkg.sv
// Only the supported integer subset is encoded, and data memory is a word array of MEM_WORDS
`default_nettype none

package mipsPkg;

    // Datapath sizes
    localparam int WORD_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 5;

    // Data memory geometry, word addressed
    localparam int MEM_WORDS      = 64;
    localparam int MEM_ADDR_WIDTH = $clog2(MEM_WORDS);

    typedef logic [WORD_WIDTH-1:0]     wordT;
    typedef logic [REG_ADDR_WIDTH-1:0] regAddrT;

    // Decoded instruction identifiers
    typedef enum logic [4:0] {
        NOP,
        ADD,
        ADDU,
        SUB,
        SUBU,
        AND,
        OR,
        XOR,
        NOR,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        SLLV,
        SRLV,
        SRAV,
        ADDI,
        ADDIU,
        ANDI,
        ORI,
        XORI,
        SLTI,
        SLTIU,
        LUI,
        LW,
        SW
    } instrIdT;

    typedef enum logic {
        FORMAT_R,
        FORMAT_I
    } formatT;

    typedef enum logic [2:0] {
        FUNC_ARITH,
        FUNC_LOGICAL,
        FUNC_SHIFT,
        FUNC_MEMLOAD,
        FUNC_MEMSTORE,
        FUNC_OTHER
    } funcTypeT;

    // ALU operation select
    typedef enum logic [3:0] {
        ALU_ZERO,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_NOR,
        ALU_XOR,
        ALU_LUI,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } aluOpT;

endpackage

`default_nettype wire

// File: memBus.sv
// Four-phase bus, the master holds we, addr and wdata stable while req is high
`timescale 1ns/1ns
`default_nettype none

interface memBus;
    import mipsPkg::*;

    logic                      req;
    logic                      ack;
    logic                      we;
    // Word index, not a byte address
    logic [MEM_ADDR_WIDTH-1:0] addr;
    wordT                      wdata;
    wordT                      rdata;

    modport master (
        output req,
        output we,
        output addr,
        output wdata,
        input  ack,
        input  rdata
    );

    modport slave (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output ack,
        output rdata
    );

endinterface

`default_nettype wire

// File: instrCategorizer.sv
// Combinational, unknown IDs fall back to FORMAT_R and FUNC_OTHER
`timescale 1ns/1ns
`default_nettype none

module instrCategorizer (
    input  mipsPkg::instrIdT  instr,
    output mipsPkg::formatT   format,
    output mipsPkg::funcTypeT funcType
);
    import mipsPkg::*;

    always_comb
    begin
        format   = FORMAT_R;
        funcType = FUNC_OTHER;
        case (instr)
            ADD, ADDU, SUB, SUBU, SLT, SLTU:
            begin
                format   = FORMAT_R;
                funcType = FUNC_ARITH;
            end
            AND, OR, XOR, NOR:
            begin
                format   = FORMAT_R;
                funcType = FUNC_LOGICAL;
            end
            SLL, SRL, SRA:
            begin
                format   = FORMAT_R;
                funcType = FUNC_SHIFT;
            end
            // Variable shifts take the amount from rs
            SLLV, SRLV, SRAV:
            begin
                format   = FORMAT_R;
                funcType = FUNC_ARITH;
            end
            ADDI, ADDIU, SLTI, SLTIU, LUI:
            begin
                format   = FORMAT_I;
                funcType = FUNC_ARITH;
            end
            ANDI, ORI, XORI:
            begin
                format   = FORMAT_I;
                funcType = FUNC_LOGICAL;
            end
            LW:
            begin
                format   = FORMAT_I;
                funcType = FUNC_MEMLOAD;
            end
            SW:
            begin
                format   = FORMAT_I;
                funcType = FUNC_MEMSTORE;
            end
            default:
            begin
                format   = FORMAT_R;
                funcType = FUNC_OTHER;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: aluExecute.sv
// Combinational ALU, loads and stores only form the address sum here
`timescale 1ns/1ns
`default_nettype none

module aluExecute (
    input  mipsPkg::instrIdT  instr,
    input  mipsPkg::wordT     dataRs,
    input  mipsPkg::wordT     dataRt,
    input  logic [15:0]       imm16,
    input  logic [4:0]        shamt,
    input  mipsPkg::regAddrT  addrRt,
    input  mipsPkg::regAddrT  addrRd,
    output mipsPkg::wordT     result,
    output mipsPkg::regAddrT  regWriteAddr,
    output mipsPkg::wordT     memWriteData,
    output mipsPkg::funcTypeT funcType
);
    import mipsPkg::*;

    formatT format;
    aluOpT  aluOp;
    wordT   imm32;
    wordT   srcA;
    wordT   srcB;

    instrCategorizer instrCategorizer_i (
        .instr    (instr),
        .format   (format),
        .funcType (funcType)
    );

    always_comb
    begin
        if ((funcType == FUNC_MEMLOAD) || (funcType == FUNC_MEMSTORE))
        begin
            aluOp = ALU_ADD;
        end
        else
        begin
            case (instr)
                ADD, ADDU, ADDI, ADDIU: aluOp = ALU_ADD;
                SUB, SUBU:              aluOp = ALU_SUB;
                AND, ANDI:              aluOp = ALU_AND;
                OR, ORI:                aluOp = ALU_OR;
                XOR, XORI:              aluOp = ALU_XOR;
                NOR:                    aluOp = ALU_NOR;
                SLT, SLTI:              aluOp = ALU_SLT;
                SLTU, SLTIU:            aluOp = ALU_SLTU;
                SLL, SLLV:              aluOp = ALU_SLL;
                SRL, SRLV:              aluOp = ALU_SRL;
                SRA, SRAV:              aluOp = ALU_SRA;
                LUI:                    aluOp = ALU_LUI;
                default:                aluOp = ALU_ZERO;
            endcase
        end
    end

    // Logical immediates are zero extended
    assign imm32 = (funcType == FUNC_LOGICAL) ? {16'b0, imm16} : {{16{imm16[15]}}, imm16};

    assign srcA = (funcType == FUNC_SHIFT) ? {27'b0, shamt} : dataRs;
    assign srcB = (format == FORMAT_I) ? imm32 : dataRt;

    always_comb
    begin
        case (aluOp)
            ALU_ADD:  result = srcA + srcB;
            ALU_SUB:  result = srcA - srcB;
            ALU_AND:  result = srcA & srcB;
            ALU_OR:   result = srcA | srcB;
            ALU_NOR:  result = ~(srcA | srcB);
            ALU_XOR:  result = srcA ^ srcB;
            ALU_LUI:  result = srcB << 16;
            ALU_SLT:  result = ($signed(srcA) < $signed(srcB)) ? 32'd1 : 32'd0;
            ALU_SLTU: result = (srcA < srcB) ? 32'd1 : 32'd0;
            ALU_SLL:  result = srcB << srcA[4:0];
            ALU_SRL:  result = srcB >> srcA[4:0];
            ALU_SRA:  result = $signed(srcB) >>> srcA[4:0];
            default:  result = '0;
        endcase
    end

    assign regWriteAddr = (format == FORMAT_R) ? addrRd : addrRt;
    assign memWriteData = dataRt;

endmodule

`default_nettype wire

// File: loadStoreSeq.sv
// One instruction in flight, issue inputs must stay stable until issueAck is seen
`timescale 1ns/1ns
`default_nettype none

module loadStoreSeq (
    input  logic              clk,
    input  logic              rstN,
    input  logic              issueReq,
    output logic              issueAck,
    input  mipsPkg::instrIdT  instr,
    input  mipsPkg::wordT     dataRs,
    input  mipsPkg::wordT     dataRt,
    input  logic [15:0]       imm16,
    input  logic [4:0]        shamt,
    input  mipsPkg::regAddrT  addrRt,
    input  mipsPkg::regAddrT  addrRd,
    output mipsPkg::wordT     result,
    output mipsPkg::regAddrT  regWriteAddr,
    memBus.master             bus
);
    import mipsPkg::*;

    typedef enum logic [1:0] {
        IDLE,
        BUS_REQ,
        BUS_REL,
        DONE
    } seqStateT;

    seqStateT state;
    wordT     aluResult;
    wordT     memWriteData;
    regAddrT  aluRegAddr;
    funcTypeT funcType;
    logic     isMem;

    aluExecute aluExecute_i (
        .instr        (instr),
        .dataRs       (dataRs),
        .dataRt       (dataRt),
        .imm16        (imm16),
        .shamt        (shamt),
        .addrRt       (addrRt),
        .addrRd       (addrRd),
        .result       (aluResult),
        .regWriteAddr (aluRegAddr),
        .memWriteData (memWriteData),
        .funcType     (funcType)
    );

    assign isMem = (funcType == FUNC_MEMLOAD) || (funcType == FUNC_MEMSTORE);

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            state    <= IDLE;
            issueAck <= 1'b0;
            bus.req  <= 1'b0;
            bus.we   <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE:
                    if (issueReq)
                    begin
                        if (isMem)
                        begin
                            bus.req <= 1'b1;
                            bus.we  <= (funcType == FUNC_MEMSTORE);
                            state   <= BUS_REQ;
                        end
                        else
                        begin
                            issueAck <= 1'b1;
                            state    <= DONE;
                        end
                    end
                BUS_REQ:
                    if (bus.ack)
                    begin
                        bus.req <= 1'b0;
                        state   <= BUS_REL;
                    end
                // Wait for the slave to finish its half of the handshake
                BUS_REL:
                    if (!bus.ack)
                    begin
                        issueAck <= 1'b1;
                        state    <= DONE;
                    end
                DONE:
                    if (!issueReq)
                    begin
                        issueAck <= 1'b0;
                        state    <= IDLE;
                    end
                default:
                    state <= IDLE;
            endcase
        end
    end

    // Result, write address and bus payload
    always_ff @(posedge clk)
    begin
        if ((state == IDLE) && issueReq)
        begin
            result       <= aluResult;
            regWriteAddr <= aluRegAddr;
            bus.addr     <= aluResult[MEM_ADDR_WIDTH+1:2];
            bus.wdata    <= memWriteData;
        end
        else if ((state == BUS_REQ) && bus.ack && (funcType == FUNC_MEMLOAD))
        begin
            result <= bus.rdata;
        end
    end

endmodule

`default_nettype wire

// File: memArbiter.sv
// Two masters, one slave, a grant is only released after the full four-phase return
`timescale 1ns/1ns
`default_nettype none

module memArbiter (
    input  logic  clk,
    input  logic  rstN,
    memBus.slave  mLsu,
    memBus.slave  mHost,
    memBus.master s
);

    typedef enum logic [1:0] {
        GRANT_NONE,
        GRANT_LSU,
        GRANT_HOST
    } grantT;

    grantT grant;
    // Set when the host side was served last
    logic  lastHost;

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            grant    <= GRANT_NONE;
            lastHost <= 1'b1;
        end
        else
        begin
            case (grant)
                GRANT_NONE:
                    if (mLsu.req && (!mHost.req || lastHost))
                    begin
                        grant    <= GRANT_LSU;
                        lastHost <= 1'b0;
                    end
                    else if (mHost.req)
                    begin
                        grant    <= GRANT_HOST;
                        lastHost <= 1'b1;
                    end
                GRANT_LSU:
                    if (!mLsu.req && !s.ack)
                        grant <= GRANT_NONE;
                GRANT_HOST:
                    if (!mHost.req && !s.ack)
                        grant <= GRANT_NONE;
                default:
                    grant <= GRANT_NONE;
            endcase
        end
    end

    // Forward the granted master only
    always_comb
    begin
        s.req       = 1'b0;
        s.we        = 1'b0;
        s.addr      = '0;
        s.wdata     = '0;
        mLsu.ack    = 1'b0;
        mLsu.rdata  = '0;
        mHost.ack   = 1'b0;
        mHost.rdata = '0;
        case (grant)
            GRANT_LSU:
            begin
                s.req      = mLsu.req;
                s.we       = mLsu.we;
                s.addr     = mLsu.addr;
                s.wdata    = mLsu.wdata;
                mLsu.ack   = s.ack;
                mLsu.rdata = s.rdata;
            end
            GRANT_HOST:
            begin
                s.req       = mHost.req;
                s.we        = mHost.we;
                s.addr      = mHost.addr;
                s.wdata     = mHost.wdata;
                mHost.ack   = s.ack;
                mHost.rdata = s.rdata;
            end
            default:
            begin
                s.req = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: dataMemory.sv
// Word-only access, contents are undefined after reset and rdata is old data on a write
`timescale 1ns/1ns
`default_nettype none

module dataMemory (
    input  logic clk,
    input  logic rstN,
    memBus.slave bus
);
    import mipsPkg::*;

    wordT mem [MEM_WORDS];

    // Ack follows req one cycle late
    always_ff @(posedge clk)
    begin
        if (!rstN)
            bus.ack <= 1'b0;
        else
            bus.ack <= bus.req;
    end

    // Access on the rising req edge only
    always_ff @(posedge clk)
    begin
        if (bus.req && !bus.ack)
        begin
            if (bus.we)
                mem[bus.addr] <= bus.wdata;
            bus.rdata <= mem[bus.addr];
        end
    end

endmodule

`default_nettype wire

// File: execUnitTop.sv
// Host pins follow the four-phase rule, hostAddr is a word index into data memory
`timescale 1ns/1ns
`default_nettype none

module execUnitTop (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic                              issueReq,
    output logic                              issueAck,
    input  mipsPkg::instrIdT                  instr,
    input  mipsPkg::wordT                     dataRs,
    input  mipsPkg::wordT                     dataRt,
    input  logic [15:0]                       imm16,
    input  logic [4:0]                        shamt,
    input  mipsPkg::regAddrT                  addrRt,
    input  mipsPkg::regAddrT                  addrRd,
    output mipsPkg::wordT                     result,
    output mipsPkg::regAddrT                  regWriteAddr,
    input  logic                              hostReq,
    input  logic                              hostWe,
    input  logic [mipsPkg::MEM_ADDR_WIDTH-1:0] hostAddr,
    input  mipsPkg::wordT                     hostWdata,
    output logic                              hostAck,
    output mipsPkg::wordT                     hostRdata
);

    memBus lsuBus ();
    memBus hostBus ();
    memBus memBusS ();

    loadStoreSeq loadStoreSeq_i (
        .clk          (clk),
        .rstN         (rstN),
        .issueReq     (issueReq),
        .issueAck     (issueAck),
        .instr        (instr),
        .dataRs       (dataRs),
        .dataRt       (dataRt),
        .imm16        (imm16),
        .shamt        (shamt),
        .addrRt       (addrRt),
        .addrRd       (addrRd),
        .result       (result),
        .regWriteAddr (regWriteAddr),
        .bus          (lsuBus)
    );

    memArbiter memArbiter_i (
        .clk   (clk),
        .rstN  (rstN),
        .mLsu  (lsuBus),
        .mHost (hostBus),
        .s     (memBusS)
    );

    dataMemory dataMemory_i (
        .clk  (clk),
        .rstN (rstN),
        .bus  (memBusS)
    );

    // Host pins onto the second master port
    assign hostBus.req   = hostReq;
    assign hostBus.we    = hostWe;
    assign hostBus.addr  = hostAddr;
    assign hostBus.wdata = hostWdata;
    assign hostAck       = hostBus.ack;
    assign hostRdata     = hostBus.rdata;

endmodule

`default_nettype wire

// File: execUnitChecker.sv
// Handshake properties sampled on the rising clock edge of every bound execUnitTop
`timescale 1ns/1ns
`default_nettype none

module execUnitChecker (
    input logic clk,
    input logic rstN,
    input logic issueReq,
    input logic issueAck,
    input logic hostReq,
    input logic hostAck
);

    // Memory drops ack one edge after req, arbiter releases one edge later
    localparam int HOST_RELEASE_CYCLES = 3;

    // Set from the second reset edge, when the acks are defined
    logic resetHeld;

    // Number of failed assertions so far
    int failCount;

    initial
    begin
        failCount = 0;
    end

    always_ff @(posedge clk)
    begin
        resetHeld <= !rstN;
    end

    resetAcksLow: assert property (@(posedge clk)
        (resetHeld && !rstN) |-> (!issueAck && !hostAck))
        else
        begin
            $error("issueAck or hostAck high during reset");
            failCount++;
        end

    issueAckNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
        $rose(issueAck) |-> $past(issueReq))
        else
        begin
            $error("issueAck rose without issueReq");
            failCount++;
        end

    issueAckHeld: assert property (@(posedge clk) disable iff (!rstN)
        (issueAck && issueReq) |=> issueAck)
        else
        begin
            $error("issueAck dropped while issueReq still high");
            failCount++;
        end

    hostAckReleased: assert property (@(posedge clk) disable iff (!rstN)
        $fell(hostReq) |-> ##[1:HOST_RELEASE_CYCLES] !hostAck)
        else
        begin
            $error("hostAck stuck high after hostReq fell");
            failCount++;
        end

endmodule

bind execUnitTop execUnitChecker execUnitChecker_i (
    .clk      (clk),
    .rstN     (rstN),
    .issueReq (issueReq),
    .issueAck (issueAck),
    .hostReq  (hostReq),
    .hostAck  (hostAck)
);

`default_nettype wire

// File: execUnitTb.sv
// Memory words are written before they are read and every wait gives up after TIMEOUT_CYCLES
`timescale 1ns/1ns
`default_nettype none

module execUnitTb;
    import mipsPkg::*;

    localparam int TIMEOUT_CYCLES = 40;
    localparam int RAND_ROUNDS    = 4;

    logic                      clk;
    logic                      rstN;
    logic                      issueReq;
    logic                      issueAck;
    instrIdT                   instr;
    wordT                      dataRs;
    wordT                      dataRt;
    logic [15:0]               imm16;
    logic [4:0]                shamt;
    regAddrT                   addrRt;
    regAddrT                   addrRd;
    wordT                      result;
    regAddrT                   regWriteAddr;
    logic                      hostReq;
    logic                      hostWe;
    logic [MEM_ADDR_WIDTH-1:0] hostAddr;
    wordT                      hostWdata;
    logic                      hostAck;
    wordT                      hostRdata;

    int          errors;
    int          timeouts;
    int          assertFailures;
    int unsigned seed;

    instrIdT rTypeOps [10] = '{ADD, ADDU, SUB, SUBU, AND, OR, XOR, NOR, SLT, SLTU};
    instrIdT immOps   [7]  = '{ADDI, ADDIU, ANDI, ORI, XORI, SLTI, SLTIU};
    instrIdT shiftOps [6]  = '{SLL, SRL, SRA, SLLV, SRLV, SRAV};

    execUnitTop execUnitTop_i (
        .clk          (clk),
        .rstN         (rstN),
        .issueReq     (issueReq),
        .issueAck     (issueAck),
        .instr        (instr),
        .dataRs       (dataRs),
        .dataRt       (dataRt),
        .imm16        (imm16),
        .shamt        (shamt),
        .addrRt       (addrRt),
        .addrRd       (addrRd),
        .result       (result),
        .regWriteAddr (regWriteAddr),
        .hostReq      (hostReq),
        .hostWe       (hostWe),
        .hostAddr     (hostAddr),
        .hostWdata    (hostWdata),
        .hostAck      (hostAck),
        .hostRdata    (hostRdata)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #10 clk = ~clk;
    end

    function automatic wordT signExt(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    // Reference ALU
    function automatic wordT expectedResult(input instrIdT op, input wordT rs, input wordT rt,
                                            input logic [15:0] imm, input logic [4:0] sh);
        wordT sImm;
        wordT zImm;
        wordT res;
        sImm = signExt(imm);
        zImm = {16'h0000, imm};
        case (op)
            ADD, ADDU: res = rs + rt;
            SUB, SUBU: res = rs - rt;
            AND:       res = rs & rt;
            OR:        res = rs | rt;
            XOR:       res = rs ^ rt;
            NOR:       res = ~(rs | rt);
            SLT:       res = ($signed(rs) < $signed(rt)) ? 32'd1 : 32'd0;
            SLTU:      res = (rs < rt) ? 32'd1 : 32'd0;
            SLL:       res = rt << sh;
            SRL:       res = rt >> sh;
            SRA:       res = $signed(rt) >>> sh;
            SLLV:      res = rt << rs[4:0];
            SRLV:      res = rt >> rs[4:0];
            SRAV:      res = $signed(rt) >>> rs[4:0];
            ADDI:      res = rs + sImm;
            ADDIU:     res = rs + sImm;
            ANDI:      res = rs & zImm;
            ORI:       res = rs | zImm;
            XORI:      res = rs ^ zImm;
            SLTI:      res = ($signed(rs) < $signed(sImm)) ? 32'd1 : 32'd0;
            SLTIU:     res = (rs < sImm) ? 32'd1 : 32'd0;
            LUI:       res = {imm, 16'h0000};
            // Stores report the address sum
            LW, SW:    res = rs + sImm;
            default:   res = '0;
        endcase
        return res;
    endfunction

    function automatic regAddrT expectedDest(input instrIdT op, input regAddrT rt,
                                             input regAddrT rd);
        case (op)
            ADDI, ADDIU, ANDI, ORI, XORI, SLTI, SLTIU, LUI, LW, SW: return rt;
            default: return rd;
        endcase
    endfunction

    // Word index from bits 7:2 of the byte address
    function automatic logic [MEM_ADDR_WIDTH-1:0] wordIndex(input wordT rs,
                                                            input logic [15:0] imm);
        wordT sum;
        sum = rs + signExt(imm);
        return sum[MEM_ADDR_WIDTH+1:2];
    endfunction

    task automatic checkWord(input string testName, input wordT expected, input wordT actual);
        if (actual !== expected)
        begin
            $display("CHECK FAILED %s: expected %h, actual %h", testName, expected, actual);
            errors++;
        end
    endtask

    task automatic checkRegAddr(input string testName, input regAddrT expected,
                                input regAddrT actual);
        if (actual !== expected)
        begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", testName, expected, actual);
            errors++;
        end
    endtask

    task automatic checkLevel(input string testName, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("CHECK FAILED %s: expected %b, actual %b", testName, expected, actual);
            errors++;
        end
    endtask

    task automatic waitIssueAck(input logic level, input string what);
        int cycles;
        cycles = 0;
        while ((issueAck !== level) && (cycles < TIMEOUT_CYCLES))
        begin
            @(negedge clk);
            cycles++;
        end
        if (issueAck !== level)
        begin
            $display("Timeout: issueAck never went to %b in %s", level, what);
            timeouts++;
        end
    endtask

    task automatic waitHostAck(input logic level, input string what);
        int cycles;
        cycles = 0;
        while ((hostAck !== level) && (cycles < TIMEOUT_CYCLES))
        begin
            @(negedge clk);
            cycles++;
        end
        if (hostAck !== level)
        begin
            $display("Timeout: hostAck never went to %b in %s", level, what);
            timeouts++;
        end
    endtask

    // Full four-phase issue that starts and ends on a falling edge
    task automatic issueInstr(input string testName, input instrIdT op, input wordT rs,
                              input wordT rt, input logic [15:0] imm, input logic [4:0] sh,
                              input regAddrT rtAddr, input regAddrT rdAddr,
                              output wordT res, output regAddrT dest);
        instr    = op;
        dataRs   = rs;
        dataRt   = rt;
        imm16    = imm;
        shamt    = sh;
        addrRt   = rtAddr;
        addrRd   = rdAddr;
        issueReq = 1'b1;
        waitIssueAck(1'b1, testName);
        res      = result;
        dest     = regWriteAddr;
        issueReq = 1'b0;
        waitIssueAck(1'b0, testName);
    endtask

    task automatic hostWrite(input string testName, input logic [MEM_ADDR_WIDTH-1:0] addr,
                             input wordT data);
        hostAddr  = addr;
        hostWdata = data;
        hostWe    = 1'b1;
        hostReq   = 1'b1;
        waitHostAck(1'b1, testName);
        hostReq = 1'b0;
        waitHostAck(1'b0, testName);
        hostWe = 1'b0;
    endtask

    task automatic hostRead(input string testName, input logic [MEM_ADDR_WIDTH-1:0] addr,
                            output wordT data);
        hostAddr = addr;
        hostWe   = 1'b0;
        hostReq  = 1'b1;
        waitHostAck(1'b1, testName);
        data    = hostRdata;
        hostReq = 1'b0;
        waitHostAck(1'b0, testName);
    endtask

    // Issue one ALU instruction with distinct random rt and rd addresses
    task automatic runAlu(input string testName, input instrIdT op, input wordT rs,
                          input wordT rt, input logic [15:0] imm, input logic [4:0] sh);
        regAddrT rtAddr;
        regAddrT rdAddr;
        wordT    res;
        regAddrT dest;
        rtAddr = regAddrT'($urandom % 32);
        rdAddr = regAddrT'(rtAddr + 1 + ($urandom % 31));
        issueInstr(testName, op, rs, rt, imm, sh, rtAddr, rdAddr, res, dest);
        checkWord(testName, expectedResult(op, rs, rt, imm, sh), res);
        checkRegAddr({testName, " dest"}, expectedDest(op, rtAddr, rdAddr), dest);
    endtask

    task automatic testReset();
        checkLevel("reset issueAck", 1'b0, issueAck);
        checkLevel("reset hostAck", 1'b0, hostAck);
        runAlu("nop", NOP, $urandom, $urandom, 16'($urandom), 5'($urandom));
    endtask

    task automatic testRType();
        for (int round = 0; round < RAND_ROUNDS; round++)
        begin
            foreach (rTypeOps[i])
            begin
                runAlu($sformatf("rtype %s", rTypeOps[i].name()), rTypeOps[i],
                       $urandom, $urandom, 16'($urandom), 5'($urandom));
            end
        end
        // Signed and unsigned compares disagree here
        runAlu("slt min vs 1", SLT, 32'h8000_0000, 32'd1, 16'h0, 5'd0);
        runAlu("sltu min vs 1", SLTU, 32'h8000_0000, 32'd1, 16'h0, 5'd0);
        runAlu("slt 1 vs min", SLT, 32'd1, 32'h8000_0000, 16'h0, 5'd0);
        runAlu("sltu 1 vs min", SLTU, 32'd1, 32'h8000_0000, 16'h0, 5'd0);
    endtask

    task automatic testImmediate();
        for (int round = 0; round < RAND_ROUNDS; round++)
        begin
            foreach (immOps[i])
            begin
                runAlu($sformatf("imm %s", immOps[i].name()), immOps[i], $urandom, $urandom,
                       16'h8000 | 16'($urandom), 5'($urandom));
            end
            foreach (shiftOps[i])
            begin
                runAlu($sformatf("shift %s", shiftOps[i].name()), shiftOps[i], $urandom,
                       32'h8000_0000 | $urandom, 16'($urandom), 5'($urandom));
            end
            runAlu("lui", LUI, $urandom, $urandom, 16'($urandom), 5'($urandom));
        end
        runAlu("andi zero extend", ANDI, 32'hFFFF_FFFF, 32'h0, 16'h8001, 5'd0);
        runAlu("addi sign extend", ADDI, 32'h0000_0010, 32'h0, 16'hFFF8, 5'd0);
        // Zero extension of the immediate would flip both compares
        runAlu("slti negative", SLTI, 32'hFFFF_FFFC, 32'h0, 16'hFFF8, 5'd0);
        runAlu("sltiu large", SLTIU, 32'h0001_0000, 32'h0, 16'h8000, 5'd0);
    endtask

    task automatic testMemory();
        wordT    storeData;
        wordT    hostData;
        wordT    readBack;
        wordT    res;
        regAddrT dest;
        storeData = $urandom;
        issueInstr("sw then host read", SW, 32'h0000_1040, storeData, 16'hFFFC, 5'd0,
                   5'd7, 5'd9, res, dest);
        checkWord("sw address sum", expectedResult(SW, 32'h0000_1040, storeData, 16'hFFFC, 5'd0),
                  res);
        hostRead("sw then host read", wordIndex(32'h0000_1040, 16'hFFFC), readBack);
        checkWord("sw then host read", storeData, readBack);

        hostData = $urandom;
        hostWrite("host write then lw", wordIndex(32'h0000_2048, 16'h0008), hostData);
        issueInstr("host write then lw", LW, 32'h0000_2048, $urandom, 16'h0008, 5'd0,
                   5'd3, 5'd12, res, dest);
        checkWord("host write then lw", hostData, res);
        checkRegAddr("lw dest", expectedDest(LW, 5'd3, 5'd12), dest);
    endtask

    // Both masters start on the same edge
    task automatic testContention();
        logic [MEM_ADDR_WIDTH-1:0] wordA;
        logic [MEM_ADDR_WIDTH-1:0] wordB;
        wordT                      dataA;
        wordT                      dataB;
        wordT                      dataC;
        wordT                      randRt;
        wordT                      resLw;
        wordT                      resSw;
        wordT                      readB;
        wordT                      readC;
        regAddrT                   destLw;
        regAddrT                   destSw;
        wordA  = wordIndex(32'h0000_0310, 16'h0000);
        wordB  = wordA + 8;
        dataA  = $urandom;
        dataB  = $urandom;
        dataC  = $urandom;
        randRt = $urandom;
        hostWrite("contention preload", wordA, dataA);
        fork
            issueInstr("contention lw", LW, 32'h0000_0310, randRt, 16'h0000, 5'd0,
                       5'd4, 5'd5, resLw, destLw);
            hostWrite("contention host write", wordB, dataB);
        join
        checkWord("contention lw", dataA, resLw);
        checkRegAddr("contention lw dest", expectedDest(LW, 5'd4, 5'd5), destLw);

        fork
            hostRead("contention host read", wordB, readB);
            issueInstr("contention sw", SW, 32'h0000_0080, dataC, 16'hFFF8, 5'd0,
                       5'd6, 5'd8, resSw, destSw);
        join
        checkWord("contention host read", dataB, readB);
        checkWord("contention sw address sum",
                  expectedResult(SW, 32'h0000_0080, dataC, 16'hFFF8, 5'd0), resSw);
        checkRegAddr("contention sw dest", expectedDest(SW, 5'd6, 5'd8), destSw);

        hostRead("contention sw read back", wordIndex(32'h0000_0080, 16'hFFF8), readC);
        checkWord("contention sw read back", dataC, readC);
        issueInstr("contention lw of sw word", LW, 32'h0000_0080, randRt, 16'hFFF8, 5'd0,
                   5'd1, 5'd2, resLw, destLw);
        checkWord("contention lw of sw word", dataC, resLw);
    endtask

    initial
    begin
        errors    = 0;
        timeouts  = 0;
        seed      = 32'hec08;
        void'($urandom(seed));
        rstN      = 1'b0;
        issueReq  = 1'b0;
        instr     = NOP;
        dataRs    = '0;
        dataRt    = '0;
        imm16     = '0;
        shamt     = '0;
        addrRt    = '0;
        addrRd    = '0;
        hostReq   = 1'b0;
        hostWe    = 1'b0;
        hostAddr  = '0;
        hostWdata = '0;

        repeat (5) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);

        testReset();
        testRType();
        testImmediate();
        testMemory();
        testContention();

        assertFailures = execUnitTop_i.execUnitChecker_i.failCount;
        $display("Errors: %0d, assertion failures: %0d, timeouts: %0d", errors,
                 assertFailures, timeouts);
        if ((errors == 0) && (timeouts == 0) && (assertFailures == 0))
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
mipsPkg.sv
memBus.sv
instrCategorizer.sv
aluExecute.sv
loadStoreSeq.sv
memArbiter.sv
dataMemory.sv
execUnitTop.sv
execUnitChecker.sv
execUnitTb.sv
